// ==== all.f ====
src/tag_store_pkg.sv
src/tag_ram_if.sv
src/tag_way_bank.sv
src/victim_select.sv
src/tag_store_ctrl.sv
src/resp_spill.sv
src/tag_store_top.sv
dv/tb_tag_store.sv

// ==== Makefile ====
# Verilator flow for the tag store testbench
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -sv -Wno-fatal --top-module tb_tag_store \
	  -f all.f -Mdir $(OBJ_DIR) -o sim_tag_store

run: compile
	./$(OBJ_DIR)/sim_tag_store | tee $(LOG)
	grep -q -F "** PASS **" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_tag_store.sv ====
/* Directed and random traffic against a model of the tag array and round-robin pointer.
   Lock changes only while the store is idle because the victim choice samples it live */
`timescale 1ns/100ps

module tb_tag_store;
  import tag_store_pkg::*;

  localparam int          WAYS           = NUM_WAYS;
  localparam int          NUM_REQS       = 600;
  localparam int          TIMEOUT_CYCLES = NUM_REQS * 8 + 200;
  localparam logic [31:0] SEED           = 32'ha1e7;
  // Modes of the response ready driver
  localparam logic [1:0]  READY_ON       = 2'd0;
  localparam logic [1:0]  READY_OFF      = 2'd1;
  localparam logic [1:0]  READY_RAND     = 2'd2;

  logic      clk_i;
  logic      arst_n_i;
  way_ind_t  total_lock_i;
  logic      req_valid_i;
  logic      req_ready_o;
  tag_mode_e req_mode_i;
  way_ind_t  req_way_i;
  index_t    req_index_i;
  tag_t      req_tag_i;
  logic      req_dirty_i;
  logic      res_valid_o;
  logic      res_ready_i;
  way_ind_t  res_way_o;
  logic      res_hit_o;
  logic      res_evict_o;
  tag_t      res_evict_tag_o;

  // Model state and bookkeeping
  tag_entry_t  mdl_arr [WAYS][NUM_LINES];
  int          mdl_ptr     = 0;
  store_res_t  exp_q [$];
  int          err_cnt     = 0;
  int          chk_cnt     = 0;
  int          issued      = 0;
  int          cycle_cnt   = 0;
  logic [1:0]  ready_mode  = READY_ON;
  logic [31:0] stim_state  = SEED;
  logic [31:0] stall_state = SEED ^ 32'h5a5a_0000;

  tag_store_top dut_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .total_lock_i    (total_lock_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_mode_i      (req_mode_i),
    .req_way_i       (req_way_i),
    .req_index_i     (req_index_i),
    .req_tag_i       (req_tag_i),
    .req_dirty_i     (req_dirty_i),
    .res_valid_o     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .res_way_o       (res_way_o),
    .res_hit_o       (res_hit_o),
    .res_evict_o     (res_evict_o),
    .res_evict_tag_o (res_evict_tag_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Expected response of one request and the model update the store would make
  function automatic store_res_t ref_step(input store_req_t r, input way_ind_t lock);
    store_res_t res;
    tag_entry_t cur [WAYS];
    tag_entry_t e;
    way_ind_t   cand;
    int         w;
    int         sel;
    int         hit_w;
    int         free_w;
    int         rr_w;
    int         flush_w;
    res     = '0;
    e       = '0;
    hit_w   = -1;
    free_w  = -1;
    rr_w    = -1;
    flush_w = -1;
    cand    = r.way & ~lock;
    for (int k = 0; k < WAYS; k++) begin
      cur[k] = mdl_arr[k][r.index];
    end
    // Downward walk leaves the lowest match in each slot
    for (int k = WAYS - 1; k >= 0; k--) begin
      if (r.way[k]) flush_w = k;
      if (r.way[k] && cur[k].valid && cur[k].tag == r.tag) hit_w = k;
      if (cand[k] && !cur[k].valid) free_w = k;
    end
    // First candidate at or after the pointer with wrap
    for (int i = 0; i < WAYS; i++) begin
      w = (mdl_ptr + i) % WAYS;
      if (cand[w] && rr_w < 0) rr_w = w;
    end
    res.hit = (r.mode == LOOKUP) && (hit_w >= 0);
    if (r.mode == FLUSH) begin
      sel = flush_w;
    end else if (res.hit) begin
      sel = hit_w;
    end else if (free_w >= 0) begin
      sel = free_w;
    end else begin
      sel = rr_w;
      if (rr_w >= 0) mdl_ptr = (rr_w + 1) % WAYS;
    end
    if (sel >= 0) begin
      e            = cur[sel];
      res.way[sel] = 1'b1;
    end
    res.evict     = !res.hit && e.valid && e.dirty;
    res.evict_tag = (!res.hit && e.valid) ? e.tag : '0;
    // Tag array update
    if (sel >= 0) begin
      if (r.mode == FLUSH) begin
        mdl_arr[sel][r.index] = '0;
      end else if (!res.hit) begin
        mdl_arr[sel][r.index] = '{valid: 1'b1, dirty: r.dirty, tag: r.tag};
      end else if (r.dirty) begin
        mdl_arr[sel][r.index].dirty = 1'b1;
      end
    end
    return res;
  endfunction

  // Sends one request and can check that the response appears 2 cycles after accept
  task automatic send_req(input tag_mode_e mode, input way_ind_t way, input index_t index,
                          input tag_t tag, input logic dirty, input way_ind_t lock,
                          input logic check_lat);
    store_req_t r;
    r = '{mode: mode, way: way, index: index, tag: tag, dirty: dirty};
    // An idle store means the previous response has left the controller
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    req_valid_i  <= 1'b1;
    req_mode_i   <= mode;
    req_way_i    <= way;
    req_index_i  <= index;
    req_tag_i    <= tag;
    req_dirty_i  <= dirty;
    total_lock_i <= lock;
    exp_q.push_back(ref_step(r, lock));
    issued++;
    do begin
      @(negedge clk_i);
    end while (!req_ready_o);
    // Accept edge
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    if (check_lat) begin
      repeat (2) begin
        @(negedge clk_i);
        check_val("res_valid_o", 32'(res_valid_o), 32'd0);
      end
      @(negedge clk_i);
      check_val("res_valid_o", 32'(res_valid_o), 32'd1);
    end
  endtask

  task automatic send_random();
    logic [31:0] r;
    tag_mode_e   mode;
    way_ind_t    way;
    way_ind_t    lock;
    stim_state = xorshift(stim_state);
    r          = stim_state;
    mode       = (r[3:0] < 4'd3) ? FLUSH : LOOKUP;
    way        = (r[5:4] == 2'd0) ? r[9:6] : '1;
    lock       = (r[12:10] == 3'd0) ? r[16:13] : '0;
    // Four sets and six tags keep hits and evictions frequent
    send_req(mode, way, {r[19:18], 4'h5}, 12'h3c0 + 12'(r[23:20] % 4'd6),
             r[24], lock, 1'b0);
  endtask

  task automatic print_summary();
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
  endtask

  // Response ready changes on the rising edge
  initial begin : drive_ready
    res_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      stall_state = xorshift(stall_state);
      case (ready_mode)
        READY_ON:  res_ready_i <= 1'b1;
        READY_OFF: res_ready_i <= 1'b0;
        default:   res_ready_i <= (stall_state[1:0] != 2'b00);
      endcase
    end
  end

  // In-order compare plus hold checks while stalled
  initial begin : compare_responses
    store_res_t exp;
    store_res_t held;
    logic       stalled;
    stalled = 1'b0;
    held    = '0;
    forever begin
      @(negedge clk_i);
      if (stalled) begin
        check_val("res_valid_o", 32'(res_valid_o), 32'd1);
        check_val("res_way_o", 32'(res_way_o), 32'(held.way));
        check_val("res_hit_o", 32'(res_hit_o), 32'(held.hit));
        check_val("res_evict_o", 32'(res_evict_o), 32'(held.evict));
        check_val("res_evict_tag_o", 32'(res_evict_tag_o), 32'(held.evict_tag));
      end
      if (arst_n_i && res_valid_o && res_ready_i) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("Response arrived with no request outstanding at %0t", $time);
        end else begin
          exp = exp_q.pop_front();
          check_val("res_way_o", 32'(res_way_o), 32'(exp.way));
          check_val("res_hit_o", 32'(res_hit_o), 32'(exp.hit));
          check_val("res_evict_o", 32'(res_evict_o), 32'(exp.evict));
          check_val("res_evict_tag_o", 32'(res_evict_tag_o), 32'(exp.evict_tag));
        end
      end
      stalled = arst_n_i && res_valid_o && !res_ready_i;
      held    = '{way: res_way_o, hit: res_hit_o, evict: res_evict_o,
                  evict_tag: res_evict_tag_o};
    end
  end

  initial begin : watchdog
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    err_cnt++;
    $display("Timeout after %0d cycles, %0d responses still missing", cycle_cnt, exp_q.size());
    print_summary();
    $finish;
  end

  initial begin : main_seq
    arst_n_i     = 1'b0;
    req_valid_i  = 1'b0;
    req_mode_i   = LOOKUP;
    req_way_i    = '0;
    req_index_i  = '0;
    req_tag_i    = '0;
    req_dirty_i  = 1'b0;
    total_lock_i = '0;
    for (int w = 0; w < WAYS; w++) begin
      for (int l = 0; l < NUM_LINES; l++) begin
        mdl_arr[w][l] = '0;
      end
    end
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Idle state after reset
    @(negedge clk_i);
    check_val("req_ready_o", 32'(req_ready_o), 32'd1);
    check_val("res_valid_o", 32'(res_valid_o), 32'd0);

    // Miss on an empty set and then a hit on the same way
    send_req(LOOKUP, 4'b0110, 6'd10, 12'h123, 1'b0, '0, 1'b1);
    send_req(LOOKUP, 4'b0110, 6'd10, 12'h123, 1'b0, '0, 1'b1);

    // Dirty upgrade and flush with writeback followed by a miss
    send_req(LOOKUP, 4'hf, 6'd20, 12'h456, 1'b0, '0, 1'b1);
    send_req(LOOKUP, 4'hf, 6'd20, 12'h456, 1'b1, '0, 1'b1);
    send_req(FLUSH, 4'b0001, 6'd20, 12'h000, 1'b0, '0, 1'b1);
    send_req(LOOKUP, 4'hf, 6'd20, 12'h456, 1'b0, '0, 1'b1);

    // Fill the set with odd ways dirty and then force round-robin misses with some ways locked
    for (int w = 0; w < WAYS; w++) begin
      send_req(LOOKUP, 4'hf, 6'd30, 12'h100 + 12'(w), w[0], '0, 1'b1);
    end
    for (int k = 0; k < 6; k++) begin
      send_req(LOOKUP, 4'hf, 6'd30, 12'h200 + 12'(k), k[0],
               way_ind_t'(24'h0c1020 >> (4 * k)), 1'b1);
    end

    // Two responses fill the spill stage and the third waits in the controller
    @(negedge clk_i);
    ready_mode = READY_OFF;
    repeat (3) send_random();
    // Without the stall the controller would be idle again by now
    repeat (3) @(negedge clk_i);
    check_val("req_ready_o", 32'(req_ready_o), 32'd0);
    check_val("res_valid_o", 32'(res_valid_o), 32'd1);
    ready_mode = READY_ON;

    // Random traffic with response stalls
    @(negedge clk_i);
    ready_mode = READY_RAND;
    while (issued < NUM_REQS) send_random();

    @(negedge clk_i);
    ready_mode = READY_ON;
    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    print_summary();
    $finish;
  end

endmodule

// ==== src/tag_store_top.sv ====
/* Response valid follows accept by 2 cycles, requests are at least 3 cycles apart */
`timescale 1ns/100ps

module tag_store_top (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  tag_store_pkg::way_ind_t  total_lock_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  tag_store_pkg::tag_mode_e req_mode_i,
  input  tag_store_pkg::way_ind_t  req_way_i,
  input  tag_store_pkg::index_t    req_index_i,
  input  tag_store_pkg::tag_t      req_tag_i,
  input  logic                     req_dirty_i,
  output logic                     res_valid_o,
  input  logic                     res_ready_i,
  output tag_store_pkg::way_ind_t  res_way_o,
  output logic                     res_hit_o,
  output logic                     res_evict_o,
  output tag_store_pkg::tag_t      res_evict_tag_o
);
  import tag_store_pkg::*;

  store_req_t req;
  store_res_t ctrl_res;
  store_res_t spill_res;
  logic       ctrl_res_valid;
  logic       ctrl_res_ready;
  logic       choose;
  way_ind_t   enable;
  way_ind_t   valid_bits;
  way_ind_t   victim;
  way_ind_t   hit;

  tag_ram_if ram_if ();

  assign req = '{
    mode:  req_mode_i,
    way:   req_way_i,
    index: req_index_i,
    tag:   req_tag_i,
    dirty: req_dirty_i
  };

  tag_store_ctrl ctrl_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req),
    .ram          (ram_if.ctrl),
    .hit_i        (hit),
    .choose_o     (choose),
    .enable_o     (enable),
    .valid_bits_o (valid_bits),
    .victim_i     (victim),
    .res_o        (ctrl_res),
    .res_valid_o  (ctrl_res_valid),
    .res_ready_i  (ctrl_res_ready)
  );

  // Compare tag and way are sampled by the bank on the accept edge
  tag_way_bank bank_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .ram       (ram_if.bank),
    .cmp_tag_i (req.tag),
    .cmp_way_i (req.way),
    .hit_o     (hit)
  );

  victim_select victim_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .choose_i     (choose),
    .enable_i     (enable),
    .lock_i       (total_lock_i),
    .valid_bits_i (valid_bits),
    .victim_o     (victim)
  );

  resp_spill spill_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (ctrl_res_valid),
    .ready_o  (ctrl_res_ready),
    .data_i   (ctrl_res),
    .valid_o  (res_valid_o),
    .ready_i  (res_ready_i),
    .data_o   (spill_res)
  );

  assign res_way_o       = spill_res.way;
  assign res_hit_o       = spill_res.hit;
  assign res_evict_o     = spill_res.evict;
  assign res_evict_tag_o = spill_res.evict_tag;

endmodule

// ==== src/resp_spill.sv ====
/* Two entries in order, ready_o never depends on ready_i */
`timescale 1ns/100ps

module resp_spill (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  input  tag_store_pkg::store_res_t data_i,
  output logic                      valid_o,
  input  logic                      ready_i,
  output tag_store_pkg::store_res_t data_o
);
  import tag_store_pkg::*;

  // Entry a drives the output, entry b catches one extra response
  logic       a_full_q;
  logic       b_full_q;
  store_res_t a_q;
  store_res_t b_q;
  logic       in_fire;
  logic       out_fire;
  logic       a_load;
  logic       b_load;
  logic       a_from_b;

  assign ready_o  = ~b_full_q;
  assign valid_o  = a_full_q;
  assign data_o   = a_q;
  assign in_fire  = valid_i & ready_o;
  assign out_fire = a_full_q & ready_i;

  assign a_load   = in_fire & (~a_full_q | out_fire);
  assign b_load   = in_fire & a_full_q & ~out_fire;
  // b moves up when the head leaves
  assign a_from_b = b_full_q & out_fire;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_load | a_from_b | (a_full_q & ~out_fire);
      b_full_q <= b_load | (b_full_q & ~out_fire);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_from_b) begin
      a_q <= b_q;
    end else if (a_load) begin
      a_q <= data_i;
    end
    if (b_load) begin
      b_q <= data_i;
    end
  end

endmodule

// ==== src/tag_store_ctrl.sv ====
/* One request in flight. Multiple hits resolve to the lowest way,
   and an empty way mask still returns a response with nothing written */
`timescale 1ns/100ps

module tag_store_ctrl (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  tag_store_pkg::store_req_t req_i,
  tag_ram_if.ctrl                   ram,
  input  tag_store_pkg::way_ind_t   hit_i,
  output logic                      choose_o,
  output tag_store_pkg::way_ind_t   enable_o,
  output tag_store_pkg::way_ind_t   valid_bits_o,
  input  tag_store_pkg::way_ind_t   victim_i,
  output tag_store_pkg::store_res_t res_o,
  output logic                      res_valid_o,
  input  logic                      res_ready_i
);
  import tag_store_pkg::*;

  logic       busy_q;
  logic       hold_q;
  store_req_t req_q;
  logic       accept;
  logic       res_fire;
  logic       is_hit;
  way_ind_t   sel_way;
  tag_entry_t sel_entry;

  // AND-OR mux of the read data by a one-hot way
  function automatic tag_entry_t pick_entry(way_ind_t sel, tag_entry_t [NUM_WAYS-1:0] rd);
    tag_entry_t e;
    e = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (sel[w]) begin
        e = e | rd[w];
      end
    end
    return e;
  endfunction

  assign req_ready_o = ~busy_q;
  assign accept      = req_valid_i & ~busy_q;
  // Read valid is a pulse, hold_q keeps the response up while stalled
  assign res_valid_o = busy_q & ((|ram.rvalid) | hold_q);
  assign res_fire    = res_valid_o & res_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      hold_q <= 1'b0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end else if (res_fire) begin
        busy_q <= 1'b0;
      end
      hold_q <= res_valid_o & ~res_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  // Victim selection inputs
  assign enable_o = req_q.way;
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_valid_bits
    assign valid_bits_o[w] = ram.rdata[w].valid;
  end

  assign is_hit = (req_q.mode == LOOKUP) & (|hit_i);

  // Way the response refers to
  always_comb begin : proc_sel
    if (req_q.mode == FLUSH) begin
      sel_way = lowest_way(req_q.way);
    end else if (is_hit) begin
      sel_way = lowest_way(hit_i);
    end else begin
      sel_way = victim_i;
    end
  end

  assign sel_entry = pick_entry(sel_way, ram.rdata);

  // Hits never evict, invalid lines report a zero tag
  assign res_o.way       = sel_way;
  assign res_o.hit       = is_hit;
  assign res_o.evict     = ~is_hit & sel_entry.valid & sel_entry.dirty;
  assign res_o.evict_tag = (~is_hit & sel_entry.valid) ? sel_entry.tag : '0;

  assign choose_o = res_fire & (req_q.mode == LOOKUP) & ~is_hit;

  // Read on accept, tag update on the response handshake
  always_comb begin : proc_ram
    ram.req   = '0;
    ram.we    = '0;
    ram.index = req_q.index;
    ram.wdata = '0;
    if (accept) begin
      // Empty mask reads every way so that read valid still returns
      ram.req   = (req_i.way == '0) ? {NUM_WAYS{1'b1}} : req_i.way;
      ram.index = req_i.index;
    end else if (res_fire) begin
      if (req_q.mode == FLUSH) begin
        ram.req = sel_way;
        ram.we  = sel_way;
      end else if (!is_hit) begin
        ram.req   = sel_way;
        ram.we    = sel_way;
        ram.wdata = '{valid: 1'b1, dirty: req_q.dirty, tag: req_q.tag};
      end else if (req_q.dirty && !sel_entry.dirty) begin
        // Clean hit upgraded to dirty
        ram.req   = sel_way;
        ram.we    = sel_way;
        ram.wdata = '{valid: 1'b1, dirty: 1'b1, tag: req_q.tag};
      end
    end
  end

endmodule

// ==== src/victim_select.sv ====
/* Combinational choice. Locked and disabled ways are never picked,
   an all-excluded mask yields a zero indicator */
`timescale 1ns/100ps

module victim_select (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    choose_i,
  input  tag_store_pkg::way_ind_t enable_i,
  input  tag_store_pkg::way_ind_t lock_i,
  input  tag_store_pkg::way_ind_t valid_bits_i,
  output tag_store_pkg::way_ind_t victim_o
);
  import tag_store_pkg::*;

  way_ind_t             cand;
  way_ind_t             free;
  way_ind_t             free_pick;
  way_ind_t             rr_pick;
  logic [WAY_IDX_W-1:0] ptr_q;
  logic [WAY_IDX_W-1:0] rr_idx;

  assign cand      = enable_i & ~lock_i;
  assign free      = cand & ~valid_bits_i;
  // An empty line always wins over the pointer
  assign free_pick = lowest_way(free);

  always_comb begin : proc_rr
    int unsigned idx;
    rr_pick = '0;
    rr_idx  = ptr_q;
    // Walk downward so the candidate nearest the pointer is written last
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      idx = (int'(ptr_q) + i) % NUM_WAYS;
      if (cand[idx]) begin
        rr_pick      = '0;
        rr_pick[idx] = 1'b1;
        rr_idx       = WAY_IDX_W'(idx);
      end
    end
  end

  assign victim_o = (|free) ? free_pick : rr_pick;

  // Advance only when the pointer path made the choice
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (choose_i && !(|free) && (|cand)) begin
      ptr_q <= (rr_idx == WAY_IDX_W'(NUM_WAYS - 1)) ? '0 : rr_idx + 1'b1;
    end
  end

endmodule

// ==== src/tag_way_bank.sv ====
/* Writes land on the strobe edge, reads capture one edge later.
   Only the valid bits are cleared by reset */
`timescale 1ns/100ps

module tag_way_bank (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  tag_ram_if.bank                 ram,
  input  tag_store_pkg::tag_t     cmp_tag_i,
  input  tag_store_pkg::way_ind_t cmp_way_i,
  output tag_store_pkg::way_ind_t hit_o
);
  import tag_store_pkg::*;

  way_ind_t rd_strobe;
  way_ind_t wr_strobe;
  index_t   rd_index_q;
  tag_t     cmp_tag_q;
  way_ind_t cmp_way_q;

  assign rd_strobe = ram.req & ~ram.we;
  assign wr_strobe = ram.req & ram.we;

  // Lookup context, captured together with the read strobe
  always_ff @(posedge clk_i) begin
    if (|rd_strobe) begin
      rd_index_q <= ram.index;
      cmp_tag_q  <= cmp_tag_i;
      cmp_way_q  <= cmp_way_i;
    end
  end

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    logic [NUM_LINES-1:0]     valid_q;
    logic [TAG_W:0]           line_q [NUM_LINES];
    logic [TAG_RAM_LATENCY:0] rd_pipe_q;
    tag_entry_t               rdata_q;

    // Valid bits per line
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        valid_q <= '0;
      end else if (wr_strobe[w]) begin
        valid_q[ram.index] <= ram.wdata.valid;
      end
    end

    // Dirty bit and tag, plus the read data register
    always_ff @(posedge clk_i) begin
      if (wr_strobe[w]) begin
        line_q[ram.index] <= {ram.wdata.dirty, ram.wdata.tag};
      end
      if (rd_pipe_q[TAG_RAM_LATENCY-1]) begin
        rdata_q <= {valid_q[rd_index_q], line_q[rd_index_q]};
      end
    end

    // Read token, stage 0 marks the strobe edge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        rd_pipe_q <= '0;
      end else begin
        rd_pipe_q <= {rd_pipe_q[TAG_RAM_LATENCY-1:0], rd_strobe[w]};
      end
    end

    assign ram.rdata[w]  = rdata_q;
    assign ram.rvalid[w] = rd_pipe_q[TAG_RAM_LATENCY];
    // Hit needs an enabled way, a valid line and an equal tag
    assign hit_o[w] = cmp_way_q[w] & rdata_q.valid & (rdata_q.tag == cmp_tag_q);
  end

endmodule

// ==== src/tag_ram_if.sv ====
/* Strobes are single cycle. Read data holds until the next access to the same way */
`timescale 1ns/100ps

interface tag_ram_if;
  import tag_store_pkg::*;

  // Controller side, one strobe bit per way
  way_ind_t                   req;
  way_ind_t                   we;
  index_t                     index;
  tag_entry_t                 wdata;

  // Bank side
  tag_entry_t [NUM_WAYS-1:0]  rdata;
  way_ind_t                   rvalid;

  modport ctrl (
    output req, we, index, wdata,
    input  rdata, rvalid
  );

  modport bank (
    input  req, we, index, wdata,
    output rdata, rvalid
  );

endinterface

// ==== src/tag_store_pkg.sv ====
/* NUM_LINES must equal 2**INDEX_W. A request targets one set of ways per access,
   and a flush clears only the lowest way of its mask */
package tag_store_pkg;

  localparam int unsigned NUM_WAYS        = 4;
  localparam int unsigned NUM_LINES       = 64;
  localparam int unsigned INDEX_W         = 6;
  localparam int unsigned TAG_W           = 12;
  localparam int unsigned TAG_RAM_LATENCY = 1;
  // Binary way number, used by the round-robin pointer
  localparam int unsigned WAY_IDX_W       = $clog2(NUM_WAYS);

  typedef logic [NUM_WAYS-1:0] way_ind_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [TAG_W-1:0]    tag_t;

  // One stored line of the tag RAM
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  typedef enum logic {
    LOOKUP = 1'b0,
    FLUSH  = 1'b1
  } tag_mode_e;

  typedef struct packed {
    tag_mode_e mode;
    way_ind_t  way;
    index_t    index;
    tag_t      tag;
    logic      dirty;
  } store_req_t;

  typedef struct packed {
    way_ind_t way;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } store_res_t;

  // Isolate the lowest set bit of a way mask
  function automatic way_ind_t lowest_way(way_ind_t mask);
    return mask & (~mask + 1'b1);
  endfunction

endpackage
